//--- hpdscratch.f
logic/hpd_pkg.sv
logic/hpd_pipe_if.sv
logic/hpd_req_arbiter.sv
logic/hpd_req_decode.sv
logic/hpd_data_array.sv
logic/hpd_rsp_route.sv
logic/hpdscratch_top.sv
test/hpdscratch_top_asserts.sv
test/hpdscratch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hpdscratch_tb
FILELIST  ?= hpdscratch.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/hpdscratch_tb.sv
// Table-driven testbench for the scratch store top level, run as the simulation top
module hpdscratch_tb;
    import hpd_pkg::*;

    localparam int NREQ = 3;
    localparam int DEPTH = 64;
    localparam int TMO = 20;

    typedef struct {
        string     name;
        int        r;
        hpd_op_e   op;
        logic [11:0] addr;
        hpd_be_t   be;
        logic      need_rsp;
        logic      exp_err;
        logic      exp_rsp;
    } test_t;

    logic            clk;
    logic            rst_n;
    logic [NREQ-1:0] core_req_valid;
    logic [NREQ-1:0] core_req_ready;
    hpd_req_t        core_req [NREQ];
    logic [NREQ-1:0] core_rsp_valid;
    hpd_rsp_t        core_rsp [NREQ];
    logic            evt_read;
    logic            evt_write;
    logic            evt_error;

    hpd_word_t model [DEPTH];
    test_t     tests [9];
    int        errors;
    int        n_tests;

    hpdscratch_top #(.NREQUESTERS(NREQ), .DEPTH(DEPTH)) dut_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .core_req_valid_i (core_req_valid),
        .core_req_ready_o (core_req_ready),
        .core_req_i       (core_req),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_o       (core_rsp),
        .evt_read_req_o   (evt_read),
        .evt_write_req_o  (evt_write),
        .evt_error_o      (evt_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_rsp(input string name, input hpd_rsp_t exp, input hpd_rsp_t act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: rsp expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_grant(input string name, input logic [NREQ-1:0] exp,
                               input logic [NREQ-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: ready expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input logic [NREQ-1:0] exp,
                              input logic [NREQ-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: rsp port expected %b actual %b", name, exp, act);
        end
    endtask

    // Event bits are {read, write, error}
    task automatic check_evt(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: events expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("Mismatch %s: latency expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic model_store(input logic [11:0] addr, input hpd_word_t wdata, input hpd_be_t be);
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                model[addr[8:3]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    function automatic hpd_rsp_t expect_rsp(input hpd_req_t req, input logic err);
        hpd_rsp_t rsp;
        rsp.rdata = (req.op == LOAD && !err) ? model[req.addr[8:3]] : '0;
        rsp.sid   = req.sid;
        rsp.tid   = req.tid;
        rsp.error = err;
        return rsp;
    endfunction

    task automatic send_req(input int r, input hpd_req_t req, input string name);
        bit ok;
        ok = 1'b0;
        @(posedge clk);
        core_req[r]       <= req;
        core_req_valid[r] <= 1'b1;
        for (int i = 0; i < TMO; i++) begin
            @(posedge clk);
            if (core_req_ready[r]) begin
                ok = 1'b1;
                break;
            end
        end
        core_req_valid[r] <= 1'b0;
        if (!ok) begin
            errors++;
            $display("%s: request was never accepted", name);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (errors == errs_before) begin
            $display("[ok]   %s", name);
        end else begin
            $display("[bad]  %s", name);
        end
    endtask

    task automatic run_single(input test_t t, input int idx);
        hpd_req_t   req;
        hpd_rsp_t   exp;
        logic [2:0] exp_evt;
        int         cyc;
        bit         got;
        int         errs_before;
        errs_before  = errors;
        req.addr     = t.addr;
        req.wdata    = {$urandom, $urandom};
        req.be       = t.be;
        req.op       = t.op;
        req.sid      = 3'(t.r);
        req.tid      = 4'(idx);
        req.need_rsp = t.need_rsp;
        exp          = expect_rsp(req, t.exp_err);
        exp_evt      = t.exp_err ? 3'b001 : (t.op == LOAD ? 3'b100 : 3'b010);
        send_req(t.r, req, t.name);
        if (t.op == STORE && !t.exp_err) begin
            model_store(req.addr, req.wdata, req.be);
        end
        got = 1'b0;
        cyc = 0;
        for (int i = 1; i <= TMO; i++) begin
            @(posedge clk);
            cyc = i;
            if (i == 1) begin
                check_evt(t.name, exp_evt, {evt_read, evt_write, evt_error});
            end else if (i == 2) begin
                // Pulse lasts one cycle
                check_evt(t.name, 3'b000, {evt_read, evt_write, evt_error});
            end
            if (|core_rsp_valid) begin
                got = 1'b1;
                break;
            end
        end
        if (t.exp_rsp && !got) begin
            errors++;
            $display("%s: no response arrived", t.name);
        end else if (t.exp_rsp) begin
            check_latency(t.name, 3, cyc);
            check_port(t.name, NREQ'(1) << t.r, core_rsp_valid);
            // Payload is broadcast on every port
            for (int p = 0; p < NREQ; p++) begin
                check_rsp(t.name, exp, core_rsp[p]);
            end
        end else if (got) begin
            errors++;
            $display("%s: response appeared for a store without need_rsp", t.name);
        end
        finish_test(t.name, errs_before);
    endtask

    // Requesters 0 and 2 collide and 0 wins first
    task automatic run_contention();
        hpd_req_t req0;
        hpd_req_t req2;
        int       seen;
        int       errs_before;
        errs_before = errors;
        req0 = '{addr: 12'h010, wdata: '0, be: '1, op: LOAD,
                 sid: 3'd0, tid: 4'd13, need_rsp: 1'b0};
        req2 = '{addr: 12'h020, wdata: '0, be: '1, op: LOAD,
                 sid: 3'd2, tid: 4'd14, need_rsp: 1'b0};
        seen = 0;
        @(posedge clk);
        core_req[0] <= req0;
        core_req[2] <= req2;
        core_req_valid <= 3'b101;
        @(posedge clk);
        check_grant("contention", 3'b001, core_req_ready);
        core_req_valid[0] <= 1'b0;
        @(posedge clk);
        check_grant("contention", 3'b100, core_req_ready);
        core_req_valid[2] <= 1'b0;
        for (int i = 1; i <= TMO && seen < 2; i++) begin
            @(posedge clk);
            if (core_rsp_valid[0]) begin
                check_latency("contention r0", 2, i);
                check_rsp("contention r0", expect_rsp(req0, 1'b0), core_rsp[0]);
                seen++;
            end
            if (core_rsp_valid[2]) begin
                check_latency("contention r2", 3, i);
                check_rsp("contention r2", expect_rsp(req2, 1'b0), core_rsp[2]);
                seen++;
            end
        end
        if (seen < 2) begin
            errors++;
            $display("contention: no response arrived for every requester");
        end
        finish_test("contention", errs_before);
    endtask

    task automatic run_burst();
        hpd_req_t reqs [3];
        int       acc_cyc [3];
        int       n_acc;
        int       n_rsp;
        int       errs_before;
        errs_before = errors;
        n_acc = 0;
        n_rsp = 0;
        for (int k = 0; k < 3; k++) begin
            reqs[k] = '{addr: (k == 1) ? 12'h020 : 12'h010, wdata: '0, be: '1, op: LOAD,
                        sid: 3'd1, tid: 4'(10 + k), need_rsp: 1'b0};
        end
        @(posedge clk);
        core_req[1]       <= reqs[0];
        core_req_valid[1] <= 1'b1;
        for (int i = 1; i <= TMO && n_rsp < 3; i++) begin
            @(posedge clk);
            if (n_acc < 3 && core_req_ready[1]) begin
                acc_cyc[n_acc] = i;
                n_acc++;
                if (n_acc < 3) begin
                    core_req[1] <= reqs[n_acc];
                end else begin
                    core_req_valid[1] <= 1'b0;
                end
            end
            if (core_rsp_valid[1] && n_rsp < n_acc) begin
                check_latency("burst", acc_cyc[n_rsp] + 3, i);
                check_rsp("burst", expect_rsp(reqs[n_rsp], 1'b0), core_rsp[1]);
                n_rsp++;
            end
        end
        core_req_valid[1] <= 1'b0;
        if (n_rsp < 3) begin
            errors++;
            $display("burst: no response arrived for every load");
        end
        finish_test("burst", errs_before);
    endtask

    initial begin
        errors  = 0;
        n_tests = 0;
        rst_n   = 1'b0;
        core_req_valid = '0;
        for (int r = 0; r < NREQ; r++) begin
            core_req[r] = '0;
        end
        void'($urandom(82));
        tests[0] = '{"full_store",     0, STORE, 12'h010, 8'hff, 1'b1, 1'b0, 1'b1};
        tests[1] = '{"load_back",      0, LOAD,  12'h010, 8'hff, 1'b0, 1'b0, 1'b1};
        tests[2] = '{"partial_store",  1, STORE, 12'h010, 8'h0f, 1'b1, 1'b0, 1'b1};
        tests[3] = '{"merged_load",    1, LOAD,  12'h010, 8'hff, 1'b0, 1'b0, 1'b1};
        tests[4] = '{"amo",            2, AMO,   12'h010, 8'hff, 1'b0, 1'b1, 1'b1};
        tests[5] = '{"oob_load",       2, LOAD,  12'h200, 8'hff, 1'b0, 1'b1, 1'b1};
        tests[6] = '{"load_after_err", 0, LOAD,  12'h010, 8'hff, 1'b0, 1'b0, 1'b1};
        tests[7] = '{"silent_store",   2, STORE, 12'h020, 8'hff, 1'b0, 1'b0, 1'b0};
        tests[8] = '{"silent_load",    2, LOAD,  12'h020, 8'hff, 1'b0, 1'b0, 1'b1};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < 9; t++) begin
            run_single(tests[t], t);
        end
        run_contention();
        run_burst();
        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/hpdscratch_top_asserts.sv
// Concurrent checks on grant, ready and response validity, bound into the scratch store top level
module hpdscratch_top_asserts #(
    parameter int NREQUESTERS = 3
) (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic [NREQUESTERS-1:0] core_req_valid_i,
    input logic [NREQUESTERS-1:0] core_req_ready_o,
    input logic [NREQUESTERS-1:0] core_rsp_valid_o
);

    logic [1:0] since_rst_q;

    // Counts the first cycles out of reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            since_rst_q <= '0;
        end else if (since_rst_q != 2'd3) begin
            since_rst_q <= since_rst_q + 2'd1;
        end
    end

    ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(core_req_ready_o)) else $error("ready is not one-hot");

    ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (core_req_ready_o & ~core_req_valid_i) == '0) else $error("ready without valid");

    rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(core_rsp_valid_o)) else $error("response valid is not one-hot");

    quiet_after_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (since_rst_q != 2'd3) |-> (core_rsp_valid_o == '0)) else $error("response right after reset");

endmodule

bind hpdscratch_top hpdscratch_top_asserts #(.NREQUESTERS(NREQUESTERS)) asserts_i (.*);

//--- logic/hpdscratch_top.sv
// Multi-requester scratch store top level, instantiated by the testbench or an SoC wrapper
module hpdscratch_top #(
    parameter int NREQUESTERS = 3,
    parameter int DEPTH       = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Core request ports
    input  logic [NREQUESTERS-1:0] core_req_valid_i,
    output logic [NREQUESTERS-1:0] core_req_ready_o,
    input  hpd_pkg::hpd_req_t      core_req_i [NREQUESTERS],

    // Core response ports
    output logic [NREQUESTERS-1:0] core_rsp_valid_o,
    output hpd_pkg::hpd_rsp_t      core_rsp_o [NREQUESTERS],

    // Events
    output logic                   evt_read_req_o,
    output logic                   evt_write_req_o,
    output logic                   evt_error_o
);
    import hpd_pkg::*;

    logic     arb_valid;
    hpd_req_t arb_req;

    hpd_exec_if #(.DEPTH(DEPTH)) exec_if ();
    hpd_result_if                result_if ();

    // Pipeline never stalls so ready is the grant itself
    hpd_req_arbiter #(
        .NREQUESTERS (NREQUESTERS),
        .req_t       (hpd_req_t)
    ) req_arbiter_i (
        .valid_i (core_req_valid_i),
        .req_i   (core_req_i),
        .gnt_o   (core_req_ready_o),
        .valid_o (arb_valid),
        .req_o   (arb_req)
    );

    hpd_req_decode #(.DEPTH(DEPTH)) req_decode_i (
        .clk_i,
        .rst_n_i,
        .valid_i         (arb_valid),
        .req_i           (arb_req),
        .exec_o          (exec_if.master),
        .evt_read_req_o,
        .evt_write_req_o,
        .evt_error_o
    );

    hpd_data_array #(.DEPTH(DEPTH)) data_array_i (
        .clk_i,
        .rst_n_i,
        .exec_i   (exec_if.slave),
        .result_o (result_if.master)
    );

    hpd_rsp_route #(.NREQUESTERS(NREQUESTERS)) rsp_route_i (
        .clk_i,
        .rst_n_i,
        .result_i         (result_if.slave),
        .core_rsp_valid_o,
        .core_rsp_o
    );

endmodule

//--- logic/hpd_rsp_route.sv
// Registers the response and steers its valid to the requester named by the source id
module hpd_rsp_route #(
    parameter int NREQUESTERS = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    hpd_result_if.slave            result_i,
    output logic [NREQUESTERS-1:0] core_rsp_valid_o,
    output hpd_pkg::hpd_rsp_t      core_rsp_o [NREQUESTERS]
);
    import hpd_pkg::*;

    logic     rsp_valid_q;
    hpd_rsp_t rsp_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= result_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_i.valid) begin
            rsp_q <= result_i.rsp;
        end
    end

    // Payload on all ports and valid on the matching one only
    always_comb begin
        for (int i = 0; i < NREQUESTERS; i++) begin
            core_rsp_valid_o[i] = rsp_valid_q && (int'(rsp_q.sid) == i);
            core_rsp_o[i]       = rsp_q;
        end
    end

endmodule

//--- logic/hpd_data_array.sv
// Word storage that applies byte-enabled stores and returns load data one cycle later
module hpd_data_array #(
    parameter int DEPTH = 64
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    hpd_exec_if.slave    exec_i,
    hpd_result_if.master result_o
);
    import hpd_pkg::*;

    localparam int BYTE_W = HPD_WORD_WIDTH / HPD_BE_WIDTH;

    hpd_word_t mem_q [DEPTH];

    // Store lands on the strobe edge, so a load right behind it sees the new word
    always_ff @(posedge clk_i) begin
        if (exec_i.valid && exec_i.is_store) begin
            for (int b = 0; b < HPD_BE_WIDTH; b++) begin
                if (exec_i.be[b]) begin
                    mem_q[exec_i.index][BYTE_W*b +: BYTE_W] <= exec_i.wdata[BYTE_W*b +: BYTE_W];
                end
            end
        end
    end

    // Strobe only for operations that expect an answer
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid <= exec_i.valid && exec_i.rsp_req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exec_i.valid) begin
            result_o.rsp.rdata <= exec_i.is_load ? mem_q[exec_i.index] : '0;
            result_o.rsp.sid   <= exec_i.sid;
            result_o.rsp.tid   <= exec_i.tid;
            result_o.rsp.error <= exec_i.error;
        end
    end

endmodule

//--- logic/hpd_req_decode.sv
// Registers the granted request and decodes it into word index, operation class and events
module hpd_req_decode #(
    parameter int DEPTH = 64
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  hpd_pkg::hpd_req_t req_i,
    hpd_exec_if.master        exec_o,
    output logic              evt_read_req_o,
    output logic              evt_write_req_o,
    output logic              evt_error_o
);
    import hpd_pkg::*;

    localparam int OFFS_W  = $clog2(HPD_BE_WIDTH);
    localparam int WADDR_W = HPD_ADDR_WIDTH - OFFS_W;
    localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WADDR_W-1:0] word_addr;
    logic               out_of_range;
    logic               op_error;
    logic               op_load;
    logic               op_store;
    logic               rsp_req;

    assign word_addr    = req_i.addr[HPD_ADDR_WIDTH-1:OFFS_W];
    assign out_of_range = int'(word_addr) >= DEPTH;

    // AMO and the spare code are unsupported
    assign op_error = out_of_range || !(req_i.op inside {LOAD, STORE});
    assign op_load  = (req_i.op == LOAD) && !op_error;
    assign op_store = (req_i.op == STORE) && !op_error;
    assign rsp_req  = op_load || op_error || (op_store && req_i.need_rsp);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exec_o.valid    <= 1'b0;
            evt_read_req_o  <= 1'b0;
            evt_write_req_o <= 1'b0;
            evt_error_o     <= 1'b0;
        end else begin
            exec_o.valid    <= valid_i;
            evt_read_req_o  <= valid_i && op_load;
            evt_write_req_o <= valid_i && op_store;
            evt_error_o     <= valid_i && op_error;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            exec_o.is_load  <= op_load;
            exec_o.is_store <= op_store;
            exec_o.index    <= word_addr[IDX_W-1:0];
            exec_o.wdata    <= req_i.wdata;
            exec_o.be       <= req_i.be;
            exec_o.sid      <= req_i.sid;
            exec_o.tid      <= req_i.tid;
            exec_o.rsp_req  <= rsp_req;
            exec_o.error    <= op_error;
        end
    end

endmodule

//--- logic/hpd_req_arbiter.sv
// Fixed-priority requester arbiter with one-hot AND-OR selection of the winning payload
module hpd_req_arbiter #(
    parameter int  NREQUESTERS = 3,
    parameter type req_t       = logic
) (
    input  logic [NREQUESTERS-1:0] valid_i,
    input  req_t                   req_i [NREQUESTERS],
    output logic [NREQUESTERS-1:0] gnt_o,
    output logic                   valid_o,
    output req_t                   req_o
);

    localparam int REQ_W = $bits(req_t);

    logic [REQ_W-1:0] mux_bits;

    // Lowest index wins
    always_comb begin : grant_sel
        logic taken;
        taken = 1'b0;
        gnt_o = '0;
        for (int i = 0; i < NREQUESTERS; i++) begin
            if (valid_i[i] && !taken) begin
                gnt_o[i] = 1'b1;
                taken    = 1'b1;
            end
        end
    end

    // AND-OR mux that relies on a one-hot grant
    always_comb begin : payload_mux
        mux_bits = '0;
        for (int i = 0; i < NREQUESTERS; i++) begin
            mux_bits = mux_bits | ({REQ_W{gnt_o[i]}} & REQ_W'(req_i[i]));
        end
    end

    assign req_o   = req_t'(mux_bits);
    assign valid_o = |gnt_o;

endmodule

//--- logic/hpd_pipe_if.sv
// Stage-to-stage interfaces carrying decoded operations into the array and results out of it
interface hpd_exec_if #(
    parameter int DEPTH = 64
);
    import hpd_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic                     valid;
    logic                     is_load;
    logic                     is_store;
    logic [IDX_W-1:0]         index;
    hpd_word_t                wdata;
    hpd_be_t                  be;
    logic [HPD_SID_WIDTH-1:0] sid;
    logic [HPD_TID_WIDTH-1:0] tid;
    logic                     rsp_req;
    logic                     error;

    modport master (
        output valid, is_load, is_store, index, wdata, be, sid, tid, rsp_req, error
    );

    modport slave (
        input  valid, is_load, is_store, index, wdata, be, sid, tid, rsp_req, error
    );

endinterface

interface hpd_result_if;
    import hpd_pkg::*;

    // One-cycle strobe per response
    logic     valid;
    hpd_rsp_t rsp;

    modport master (
        output valid, rsp
    );

    modport slave (
        input  valid, rsp
    );

endinterface

//--- logic/hpd_pkg.sv
// Widths, operation codes and request/response structs shared by every scratch store block
package hpd_pkg;

    localparam int HPD_WORD_WIDTH = 64;
    localparam int HPD_BE_WIDTH   = HPD_WORD_WIDTH / 8;
    localparam int HPD_ADDR_WIDTH = 12;
    localparam int HPD_SID_WIDTH  = 3;
    localparam int HPD_TID_WIDTH  = 4;

    typedef logic [HPD_WORD_WIDTH-1:0] hpd_word_t;
    typedef logic [HPD_BE_WIDTH-1:0]   hpd_be_t;

    // Code 2'b11 is unused and decodes as unsupported
    typedef enum logic [1:0] {
        LOAD  = 2'b00,
        STORE = 2'b01,
        AMO   = 2'b10
    } hpd_op_e;

    // Core request with a byte address
    typedef struct packed {
        logic [HPD_ADDR_WIDTH-1:0] addr;
        hpd_word_t                 wdata;
        hpd_be_t                   be;
        hpd_op_e                   op;
        logic [HPD_SID_WIDTH-1:0]  sid;
        logic [HPD_TID_WIDTH-1:0]  tid;
        logic                      need_rsp;
    } hpd_req_t;

    // Core response
    typedef struct packed {
        hpd_word_t                 rdata;
        logic [HPD_SID_WIDTH-1:0]  sid;
        logic [HPD_TID_WIDTH-1:0]  tid;
        logic                      error;
    } hpd_rsp_t;

endpackage
